//--- mem_pkg.sv
package mem_pkg;

    // sizes fixed for the whole stage
    localparam int TLB_ENTRIES    = 8;
    localparam int TLB_IDX_W      = $clog2(TLB_ENTRIES);
    localparam int TIMEOUT_CYCLES = 64;
    localparam int TIMER_W        = $clog2(TIMEOUT_CYCLES + 1);
    localparam int NUM_OPS        = 4;
    localparam int NUM_REGS       = 4;
    localparam int IDX_W          = 2;

    typedef enum logic [1:0] {
        BYTE  = 2'd0,
        WORD  = 2'd1,
        DWORD = 2'd2
    } opsize_e;

    // destinations use REG, SEG and MEM only
    typedef enum logic [2:0] {
        REG = 3'd0,
        SEG = 3'd1,
        MEM = 3'd2,
        IMM = 3'd3,
        EIP = 3'd4
    } src_kind_e;

    typedef struct packed {
        src_kind_e        kind;
        logic [IDX_W-1:0] idx;
    } op_sel_t;

    typedef struct packed {
        src_kind_e        kind;
        logic [IDX_W-1:0] idx;
    } dest_sel_t;

    typedef struct packed {
        logic prot;
        logic page_fault;
        logic bus_err;
        logic misalign;
    } ie_bits_t;

    // flat word, or page number plus page offset
    typedef union packed {
        logic [31:0] flat;
        struct packed {
            logic [19:0] vpn;
            logic [11:0] off;
        } pg;
    } lin_addr_u;

    // passed through to execute untouched
    typedef struct packed {
        logic [4:0]  aluk;
        logic [23:0] p_op;
        logic [10:0] fmask;
    } ctrl_t;

    typedef struct packed {
        opsize_e                          opsize;
        logic [31:0]                      offset;
        logic [IDX_W-1:0]                 seg_idx;
        logic                             is_mem_read;
        logic                             is_write;
        logic [NUM_REGS-1:0][31:0]        regs;
        logic [NUM_REGS-1:0][31:0]        seg_base;
        logic [NUM_REGS-1:0][31:0]        seg_limit;
        op_sel_t [NUM_OPS-1:0]            op_sel;
        dest_sel_t [NUM_OPS-1:0]          dest_sel;
        logic [31:0]                      imm;
        logic [31:0]                      eip;
        ie_bits_t                         ie_in;
        ctrl_t                            ctrl;
    } mem_req_t;

    typedef struct packed {
        logic [NUM_OPS-1:0][31:0]         op_val;
        logic [NUM_OPS-1:0][31:0]         dest_addr;
        src_kind_e [NUM_OPS-1:0]          dest_kind;
        logic [31:0]                      eip;
        ie_bits_t                         ie;
        logic                             ie_out;
        ctrl_t                            ctrl;
    } mem_res_t;

    typedef struct packed {
        logic                 valid;
        logic [TLB_IDX_W-1:0] index;
        logic [19:0]          vpn;
        logic [19:0]          pfn;
        logic                 present;
        logic                 rw;
    } tlb_fill_t;

    typedef struct packed {
        logic [31:0] araddr;
        logic        arvalid;
    } axi_ar_t;

    typedef struct packed {
        logic [31:0] rdata;
        logic [1:0]  rresp;
        logic        rvalid;
    } axi_r_t;

endpackage

//--- mem_wait_timer.sv
`timescale 1ns/1ps

module mem_wait_timer (
    input  logic clk,
    input  logic rst_n,
    input  logic run,
    output logic timeout
);

    logic [mem_pkg::TIMER_W-1:0] count;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            count <= '0;
        end else if (!run) begin
            count <= '0;
        end else if (!timeout) begin
            // saturates at the limit
            count <= count + 1'b1;
        end
    end

    assign timeout = (count == mem_pkg::TIMER_W'(mem_pkg::TIMEOUT_CYCLES));

endmodule

//--- mem_addr_gen.sv
`timescale 1ns/1ps

module mem_addr_gen (
    input  mem_pkg::mem_req_t  req,
    output mem_pkg::lin_addr_u lin,
    output logic               seg_fault,
    output logic               misalign
);

    logic [1:0]  size_m1;
    logic [32:0] acc_end;
    logic [2:0]  low_end;

    always_comb begin
        case (req.opsize)
            mem_pkg::BYTE:  size_m1 = 2'd0;
            mem_pkg::WORD:  size_m1 = 2'd1;
            mem_pkg::DWORD: size_m1 = 2'd3;
            default:        size_m1 = 2'd0;
        endcase
    end

    assign lin.flat = req.seg_base[req.seg_idx] + req.offset;

    // last byte touched, with a carry bit so a wrap still faults
    assign acc_end   = {1'b0, req.offset} + {31'd0, size_m1};
    assign seg_fault = acc_end > {1'b0, req.seg_limit[req.seg_idx]};

    // accesses are not split, so crossing a dword is a fault
    assign low_end  = {1'b0, lin.pg.off[1:0]} + {1'b0, size_m1};
    assign misalign = low_end[2];

endmodule

//--- tlb.sv
`timescale 1ns/1ps

module tlb (
    input  logic               clk,
    input  logic               rst_n,
    input  mem_pkg::tlb_fill_t fill,
    input  mem_pkg::lin_addr_u lin,
    input  logic               is_write,
    output logic [31:0]        paddr,
    output logic               miss,
    output logic               prot
);

    logic [mem_pkg::TLB_ENTRIES-1:0] valid;
    logic [mem_pkg::TLB_ENTRIES-1:0] present;
    logic [mem_pkg::TLB_ENTRIES-1:0] rw;
    logic [19:0]                     vpn [mem_pkg::TLB_ENTRIES];
    logic [19:0]                     pfn [mem_pkg::TLB_ENTRIES];

    logic        hit;
    logic        hit_present;
    logic        hit_rw;
    logic [19:0] hit_pfn;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            valid <= '0;
        end else if (fill.valid) begin
            valid[fill.index] <= 1'b1;
        end
    end

    // entry contents carry no reset
    always_ff @(posedge clk) begin
        if (fill.valid) begin
            vpn[fill.index]     <= fill.vpn;
            pfn[fill.index]     <= fill.pfn;
            present[fill.index] <= fill.present;
            rw[fill.index]      <= fill.rw;
        end
    end

    // fully associative compare, highest matching index wins
    always_comb begin
        hit         = 1'b0;
        hit_present = 1'b0;
        hit_rw      = 1'b0;
        hit_pfn     = '0;
        for (int i = 0; i < mem_pkg::TLB_ENTRIES; i++) begin
            if (valid[i] && (vpn[i] == lin.pg.vpn)) begin
                hit         = 1'b1;
                hit_present = present[i];
                hit_rw      = rw[i];
                hit_pfn     = pfn[i];
            end
        end
    end

    assign miss  = !hit || !hit_present;
    assign prot  = hit && hit_present && is_write && !hit_rw;
    assign paddr = {hit_pfn, lin.pg.off};

endmodule

//--- mem_axi_read.sv
`timescale 1ns/1ps

module mem_axi_read (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             load_req,
    input  logic [31:0]      paddr,
    input  mem_pkg::opsize_e opsize,
    input  logic             start_ar,
    input  logic             capture_r,
    output mem_pkg::axi_ar_t ar,
    input  logic             arready,
    input  mem_pkg::axi_r_t  r,
    output logic             rready,
    output logic             ar_done,
    output logic             r_done,
    output logic             r_err,
    output logic [31:0]      mem_data
);

    logic [31:0] shifted;
    logic [31:0] sized;

    assign ar_done = ar.arvalid && arready;
    assign r_done  = r.rvalid && rready;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ar.arvalid <= 1'b0;
            ar.araddr  <= '0;
            rready     <= 1'b0;
            r_err      <= 1'b0;
        end else begin
            // always willing to take a beat, stray ones included
            rready <= 1'b1;
            if (ar_done) begin
                ar.arvalid <= 1'b0;
            end else if (start_ar && !ar.arvalid) begin
                ar.arvalid <= 1'b1;
                ar.araddr  <= {paddr[31:2], 2'b00};
            end
            if (load_req) begin
                r_err <= 1'b0;
            end else if (capture_r) begin
                r_err <= (r.rresp != 2'b00);
            end
        end
    end

    // move the addressed byte lane down to bit 0
    assign shifted = r.rdata >> {paddr[1:0], 3'b000};

    always_comb begin
        case (opsize)
            mem_pkg::BYTE: sized = {24'd0, shifted[7:0]};
            mem_pkg::WORD: sized = {16'd0, shifted[15:0]};
            default:       sized = shifted;
        endcase
    end

    always_ff @(posedge clk) begin
        if (load_req) begin
            mem_data <= '0;
        end else if (capture_r) begin
            mem_data <= sized;
        end
    end

endmodule

//--- opswap.sv
`timescale 1ns/1ps

module opswap (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              load_req,
    input  mem_pkg::mem_req_t req_in,
    input  logic [31:0]       paddr,
    input  logic [31:0]       mem_data,
    input  mem_pkg::ie_bits_t ie_new,
    output mem_pkg::mem_req_t req,
    output mem_pkg::mem_res_t res
);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            req <= '0;
        end else if (load_req) begin
            req <= req_in;
        end
    end

    always_comb begin
        res = '0;
        for (int i = 0; i < mem_pkg::NUM_OPS; i++) begin
            case (req.op_sel[i].kind)
                mem_pkg::REG: res.op_val[i] = req.regs[req.op_sel[i].idx];
                mem_pkg::SEG: res.op_val[i] = req.seg_base[req.op_sel[i].idx];
                mem_pkg::MEM: res.op_val[i] = mem_data;
                mem_pkg::IMM: res.op_val[i] = req.imm;
                mem_pkg::EIP: res.op_val[i] = req.eip;
                default:      res.op_val[i] = '0;
            endcase
            // register and segment targets are named by index
            res.dest_kind[i] = req.dest_sel[i].kind;
            case (req.dest_sel[i].kind)
                mem_pkg::REG, mem_pkg::SEG: res.dest_addr[i] = {30'd0, req.dest_sel[i].idx};
                mem_pkg::MEM:               res.dest_addr[i] = paddr;
                default:                    res.dest_addr[i] = '0;
            endcase
        end
        res.eip    = req.eip;
        res.ie     = req.ie_in | ie_new;
        res.ie_out = |res.ie;
        res.ctrl   = req.ctrl;
    end

endmodule

//--- mem_ctrl_fsm.sv
`timescale 1ns/1ps

module mem_ctrl_fsm (
    input  logic clk,
    input  logic rst_n,
    input  logic in_valid,
    output logic in_ready,
    input  logic need_read,
    input  logic fault,
    input  logic ar_done,
    input  logic r_done,
    input  logic timeout,
    input  logic out_ready,
    output logic out_valid,
    output logic load_req,
    output logic start_ar,
    output logic timer_run,
    output logic capture_r
);

    typedef enum logic [2:0] {
        IDLE      = 3'd0,
        CHECK     = 3'd1,
        READ_ADDR = 3'd2,
        READ_DATA = 3'd3,
        DONE      = 3'd4
    } state_e;

    state_e state;
    state_e state_nxt;

    always_comb begin
        state_nxt = state;
        case (state)
            IDLE: begin
                if (in_valid && in_ready) begin
                    state_nxt = CHECK;
                end
            end
            CHECK: begin
                if (fault || !need_read) begin
                    state_nxt = DONE;
                end else begin
                    state_nxt = READ_ADDR;
                end
            end
            READ_ADDR: begin
                if (ar_done) begin
                    state_nxt = READ_DATA;
                end
            end
            READ_DATA: begin
                if (timeout || r_done) begin
                    state_nxt = DONE;
                end
            end
            DONE: begin
                if (out_valid && out_ready) begin
                    state_nxt = IDLE;
                end
            end
            default: state_nxt = IDLE;
        endcase
    end

    // only one bundle in flight, so accept only from IDLE
    assign load_req  = (state == IDLE) && in_valid && in_ready;
    assign start_ar  = (state == READ_ADDR);
    // a timeout wins over a beat in the same cycle
    assign capture_r = (state == READ_DATA) && r_done && !timeout;
    // keep the timer saturated in DONE so bus_err holds until taken
    assign timer_run = (state == READ_DATA) || ((state == DONE) && timeout);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state     <= IDLE;
            in_ready  <= 1'b0;
            out_valid <= 1'b0;
        end else begin
            state    <= state_nxt;
            in_ready <= (state_nxt == IDLE);
            // result shows one cycle after entering DONE
            if (out_valid && out_ready) begin
                out_valid <= 1'b0;
            end else if (state == DONE) begin
                out_valid <= 1'b1;
            end
        end
    end

endmodule

//--- mem_stage.sv
`timescale 1ns/1ps

module mem_stage (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               in_valid,
    output logic               in_ready,
    input  mem_pkg::mem_req_t  in_req,
    output logic               out_valid,
    input  logic               out_ready,
    output mem_pkg::mem_res_t  out_res,
    input  mem_pkg::tlb_fill_t tlb_fill,
    output mem_pkg::axi_ar_t   ar,
    input  logic               arready,
    input  mem_pkg::axi_r_t    r,
    output logic               rready
);

    mem_pkg::mem_req_t  req;
    mem_pkg::lin_addr_u lin;
    mem_pkg::ie_bits_t  ie_new;
    logic [31:0]        paddr;
    logic [31:0]        mem_data;
    logic               seg_fault;
    logic               misalign;
    logic               tlb_miss;
    logic               tlb_prot;
    logic               fault;
    logic               ar_done;
    logic               r_done;
    logic               r_err;
    logic               timeout;
    logic               load_req;
    logic               start_ar;
    logic               timer_run;
    logic               capture_r;

    // new faults found by this stage
    assign ie_new.prot       = seg_fault | tlb_prot;
    assign ie_new.page_fault = tlb_miss;
    assign ie_new.bus_err    = r_err | timeout;
    assign ie_new.misalign   = misalign;

    // anything found in CHECK skips the bus
    assign fault = seg_fault | misalign | tlb_miss | tlb_prot;

    mem_ctrl_fsm u_ctrl (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .need_read (req.is_mem_read),
        .fault     (fault),
        .ar_done   (ar_done),
        .r_done    (r_done),
        .timeout   (timeout),
        .out_ready (out_ready),
        .out_valid (out_valid),
        .load_req  (load_req),
        .start_ar  (start_ar),
        .timer_run (timer_run),
        .capture_r (capture_r)
    );

    mem_wait_timer u_timer (
        .clk     (clk),
        .rst_n   (rst_n),
        .run     (timer_run),
        .timeout (timeout)
    );

    mem_addr_gen u_addr (
        .req       (req),
        .lin       (lin),
        .seg_fault (seg_fault),
        .misalign  (misalign)
    );

    tlb u_tlb (
        .clk      (clk),
        .rst_n    (rst_n),
        .fill     (tlb_fill),
        .lin      (lin),
        .is_write (req.is_write),
        .paddr    (paddr),
        .miss     (tlb_miss),
        .prot     (tlb_prot)
    );

    mem_axi_read u_axi (
        .clk       (clk),
        .rst_n     (rst_n),
        .load_req  (load_req),
        .paddr     (paddr),
        .opsize    (req.opsize),
        .start_ar  (start_ar),
        .capture_r (capture_r),
        .ar        (ar),
        .arready   (arready),
        .r         (r),
        .rready    (rready),
        .ar_done   (ar_done),
        .r_done    (r_done),
        .r_err     (r_err),
        .mem_data  (mem_data)
    );

    opswap u_opswap (
        .clk      (clk),
        .rst_n    (rst_n),
        .load_req (load_req),
        .req_in   (in_req),
        .paddr    (paddr),
        .mem_data (mem_data),
        .ie_new   (ie_new),
        .req      (req),
        .res      (out_res)
    );

endmodule

//--- tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen (
    output logic clk,
    output logic rst_n
);

    // 4 ns period
    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    initial begin
        rst_n = 1'b0;
        repeat (16) @(posedge clk);
        rst_n <= 1'b1;
    end

endmodule

//--- mem_stage_tb.sv
`timescale 1ns/1ps

module mem_stage_tb;

    logic               clk;
    logic               rst_n;
    logic               in_valid;
    logic               in_ready;
    mem_pkg::mem_req_t  in_req;
    logic               out_valid;
    logic               out_ready;
    mem_pkg::mem_res_t  out_res;
    mem_pkg::tlb_fill_t tlb_fill;
    mem_pkg::axi_ar_t   ar;
    logic               arready;
    mem_pkg::axi_r_t    r;
    logic               rready;

    // tlb contents as the testbench loaded them
    logic        m_valid   [8];
    logic [19:0] m_vpn     [8];
    logic [19:0] m_pfn     [8];
    logic        m_present [8];
    logic        m_rw      [8];

    mem_pkg::mem_res_t exp_q [$];
    logic [31:0]       araddr_q [$];
    int                test_len [6] = '{40, 60, 30, 30, 12, 60};
    int                errors       = 0;
    int                ar_count     = 0;
    int                total_reqs   = 0;
    logic              stall_heavy  = 1'b0;
    logic [15:0]       lfsr         = 16'd20919;

    tb_clock_gen clk_gen (
        .clk   (clk),
        .rst_n (rst_n)
    );

    mem_stage uut (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .in_req    (in_req),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out_res   (out_res),
        .tlb_fill  (tlb_fill),
        .ar        (ar),
        .arready   (arready),
        .r         (r),
        .rready    (rready)
    );

    // 16-bit Fibonacci LFSR, taps 16 14 13 11, one step per bit
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        logic        fb;
        v = '0;
        for (int i = 0; i < n; i++) begin
            fb   = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
            lfsr = {lfsr[14:0], fb};
            v    = {v[30:0], fb};
        end
        return v;
    endfunction

    // memory contents depend on every address bit
    function automatic logic [7:0] mem_byte(input logic [31:0] a);
        return (a[7:0] * 8'd37) ^ a[15:8] ^ a[23:16] ^ a[31:24] ^ 8'h5a;
    endfunction

    function automatic logic [1:0] size_minus_one(input mem_pkg::opsize_e s);
        case (s)
            mem_pkg::WORD:  return 2'd1;
            mem_pkg::DWORD: return 2'd3;
            default:        return 2'd0;
        endcase
    endfunction

    task automatic compare_val(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        if (got !== exp) begin
            $display("ERROR %s: got 0x%0h expected 0x%0h", name, got, exp);
            errors++;
        end
    endtask

    task automatic check_result(input string pre, input mem_pkg::mem_res_t got,
                                input mem_pkg::mem_res_t exp);
        for (int i = 0; i < mem_pkg::NUM_OPS; i++) begin
            compare_val($sformatf("%sop_val[%0d]", pre, i), got.op_val[i], exp.op_val[i]);
            compare_val($sformatf("%sdest_addr[%0d]", pre, i), got.dest_addr[i],
                        exp.dest_addr[i]);
            compare_val($sformatf("%sdest_kind[%0d]", pre, i), got.dest_kind[i],
                        exp.dest_kind[i]);
        end
        compare_val({pre, "eip"}, got.eip, exp.eip);
        compare_val({pre, "ie"}, got.ie, exp.ie);
        compare_val({pre, "ie_out"}, got.ie_out, exp.ie_out);
        compare_val({pre, "ctrl"}, got.ctrl, exp.ctrl);
    endtask

    // reference model of one bundle
    function automatic mem_pkg::mem_res_t predict_result(input mem_pkg::mem_req_t q,
                                                         output logic reads,
                                                         output logic [31:0] word_addr);
        mem_pkg::mem_res_t e;
        mem_pkg::ie_bits_t nf;
        logic [31:0]       lin;
        logic [31:0]       paddr;
        logic [31:0]       data;
        logic [32:0]       last;
        logic [19:0]       pfn;
        logic [1:0]        sm1;
        logic              hit;
        logic              pres;
        logic              wr_ok;
        logic              miss;
        logic              tprot;
        logic              segf;
        logic              mis;
        sm1   = size_minus_one(q.opsize);
        lin   = q.seg_base[q.seg_idx] + q.offset;
        last  = {1'b0, q.offset} + {31'd0, sm1};
        segf  = last > {1'b0, q.seg_limit[q.seg_idx]};
        mis   = (int'(lin[1:0]) + int'(sm1)) > 3;
        hit   = 1'b0;
        pres  = 1'b0;
        wr_ok = 1'b0;
        pfn   = '0;
        for (int i = 0; i < 8; i++) begin
            if (m_valid[i] && m_vpn[i] == lin[31:12]) begin
                hit   = 1'b1;
                pres  = m_present[i];
                wr_ok = m_rw[i];
                pfn   = m_pfn[i];
            end
        end
        miss      = !hit || !pres;
        tprot     = hit && pres && q.is_write && !wr_ok;
        paddr     = {pfn, lin[11:0]};
        word_addr = {paddr[31:2], 2'b00};
        reads     = q.is_mem_read && !(segf || mis || miss || tprot);
        data      = '0;
        nf        = '0;
        if (reads) begin
            // pfn top nibble D never answers, E answers with an error
            if (paddr[31:28] == 4'hd) begin
                nf.bus_err = 1'b1;
            end else begin
                for (int b = 0; b <= int'(sm1); b++) begin
                    data[8*b +: 8] = mem_byte(paddr + 32'(b));
                end
                nf.bus_err = (paddr[31:28] == 4'he);
            end
        end
        nf.prot       = segf | tprot;
        nf.page_fault = miss;
        nf.misalign   = mis;
        e = '0;
        for (int i = 0; i < mem_pkg::NUM_OPS; i++) begin
            case (q.op_sel[i].kind)
                mem_pkg::REG: e.op_val[i] = q.regs[q.op_sel[i].idx];
                mem_pkg::SEG: e.op_val[i] = q.seg_base[q.op_sel[i].idx];
                mem_pkg::MEM: e.op_val[i] = data;
                mem_pkg::IMM: e.op_val[i] = q.imm;
                default:      e.op_val[i] = q.eip;
            endcase
            e.dest_kind[i] = q.dest_sel[i].kind;
            if (q.dest_sel[i].kind == mem_pkg::MEM) begin
                e.dest_addr[i] = paddr;
            end else begin
                e.dest_addr[i] = {30'd0, q.dest_sel[i].idx};
            end
        end
        e.eip    = q.eip;
        e.ie     = q.ie_in | nf;
        e.ie_out = |e.ie;
        e.ctrl   = q.ctrl;
        return e;
    endfunction

    // pages 0-2 rw, 3-4 read only, 5 not present, 6 dead, 7 error
    function automatic mem_pkg::mem_req_t make_req(input int test_num);
        mem_pkg::mem_req_t q;
        int                kind;
        int                page;
        int                lo;
        logic [1:0]        sm1;
        logic [31:0]       lin;
        kind = test_num;
        if (kind == 6) begin
            kind = 1 + int'(rand_bits(3) % 5);
        end
        q = '0;
        for (int i = 0; i < mem_pkg::NUM_OPS; i++) begin
            q.regs[i]         = rand_bits(32);
            q.seg_base[i]     = rand_bits(32);
            q.seg_limit[i]    = rand_bits(32);
            q.op_sel[i].kind  = mem_pkg::src_kind_e'(3'(rand_bits(3) % 5));
            q.op_sel[i].idx   = 2'(rand_bits(2));
            q.dest_sel[i].kind = mem_pkg::src_kind_e'(3'(rand_bits(2) % 3));
            q.dest_sel[i].idx = 2'(rand_bits(2));
        end
        q.imm  = rand_bits(32);
        q.eip  = rand_bits(32);
        q.ctrl = 40'({rand_bits(8), rand_bits(32)});
        if (rand_bits(3) == 32'd0) begin
            q.ie_in = 4'(rand_bits(4));
        end
        q.opsize  = mem_pkg::opsize_e'(2'(rand_bits(2) % 3));
        q.seg_idx = 2'(rand_bits(2));
        q.offset  = {16'd0, 16'(rand_bits(16))} | 32'h100;
        case (kind)
            1: begin
                page       = int'(rand_bits(4) % 3);
                q.is_write = rand_bits(1) == 32'd1;
            end
            2: begin
                page          = int'(rand_bits(4) % 5);
                q.is_mem_read = 1'b1;
            end
            3: begin
                page          = int'(rand_bits(4) % 3);
                q.is_mem_read = 1'b1;
            end
            4: begin
                q.is_mem_read = rand_bits(1) == 32'd1;
                case (rand_bits(4) % 3)
                    0:       page = 5;
                    1:       page = 8 + int'(rand_bits(3));
                    default: begin
                        page       = 3 + int'(rand_bits(1));
                        q.is_write = 1'b1;
                    end
                endcase
            end
            default: begin
                page          = 6 + int'(rand_bits(1));
                q.is_mem_read = 1'b1;
            end
        endcase
        sm1 = size_minus_one(q.opsize);
        lo  = int'(rand_bits(4) % (4 - int'(sm1)));
        q.seg_limit[q.seg_idx] = q.offset + 32'(sm1) + rand_bits(8);
        if (kind == 3 && rand_bits(1) == 32'd1) begin
            // limit just below the last byte
            q.seg_limit[q.seg_idx] = q.offset + 32'(sm1) - 32'd1 - rand_bits(2);
        end else if (kind == 3) begin
            if (q.opsize == mem_pkg::BYTE) begin
                q.opsize = mem_pkg::WORD;
            end
            sm1 = size_minus_one(q.opsize);
            lo  = 4 - int'(sm1) + int'(rand_bits(4) % sm1);
        end
        lin = {20'h10 + 20'(page), 10'(rand_bits(10)), 2'(lo)};
        q.seg_base[q.seg_idx] = lin - q.offset;
        return q;
    endfunction

    task automatic fill_entry(input int idx, input logic [19:0] pfn,
                              input logic present, input logic rw);
        mem_pkg::tlb_fill_t f;
        f.valid   = 1'b1;
        f.index   = 3'(idx);
        f.vpn     = 20'h10 + 20'(idx);
        f.pfn     = pfn;
        f.present = present;
        f.rw      = rw;
        @(posedge clk);
        tlb_fill       <= f;
        m_valid[idx]   = 1'b1;
        m_vpn[idx]     = f.vpn;
        m_pfn[idx]     = pfn;
        m_present[idx] = present;
        m_rw[idx]      = rw;
    endtask

    task automatic load_tlb();
        fill_entry(0, 20'h00020, 1'b1, 1'b1);
        fill_entry(1, 20'h00031, 1'b1, 1'b1);
        fill_entry(2, 20'h00042, 1'b1, 1'b1);
        fill_entry(3, 20'h00053, 1'b1, 1'b0);
        fill_entry(4, 20'h00064, 1'b1, 1'b0);
        fill_entry(5, 20'h00075, 1'b0, 1'b1);
        fill_entry(6, 20'hd0086, 1'b1, 1'b1);
        fill_entry(7, 20'he0097, 1'b1, 1'b1);
        @(posedge clk);
        tlb_fill <= '0;
    endtask

    task automatic send_req(input mem_pkg::mem_req_t q);
        @(posedge clk);
        in_valid <= 1'b1;
        in_req   <= q;
        @(posedge clk);
        while (!in_ready) @(posedge clk);
        in_valid <= 1'b0;
    endtask

    task automatic run_test(input int num, input string name);
        mem_pkg::mem_req_t q;
        int                err0;
        int                ar0;
        int                exp_ar;
        logic              rd;
        logic [31:0]       wa;
        err0        = errors;
        ar0         = ar_count;
        exp_ar      = 0;
        stall_heavy = (num == 6);
        for (int n = 0; n < test_len[num-1]; n++) begin
            q = make_req(num);
            exp_q.push_back(predict_result(q, rd, wa));
            if (rd) begin
                exp_ar++;
                araddr_q.push_back(wa);
            end
            send_req(q);
        end
        while (exp_q.size() != 0) @(posedge clk);
        compare_val("ar transfers", 64'(ar_count - ar0), 64'(exp_ar));
        total_reqs += test_len[num-1];
        $display("test %0d %s: %0d requests, %0d errors", num, name, test_len[num-1],
                 errors - err0);
    endtask

    initial begin : main
        in_valid <= 1'b0;
        in_req   <= '0;
        tlb_fill <= '0;
        for (int i = 0; i < 8; i++) begin
            m_valid[i] = 1'b0;
        end
        wait (rst_n === 1'b1);
        repeat (2) @(posedge clk);
        load_tlb();
        run_test(1, "operand and destination select");
        run_test(2, "memory reads");
        run_test(3, "segment limit and misalign");
        run_test(4, "tlb faults");
        run_test(5, "bus errors");
        run_test(6, "back-pressure");
        $display("tests run: 6, requests: %0d, errors: %0d", total_reqs, errors);
        if (errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

    // AR and R with random delays
    initial begin : axi_responder
        logic [31:0] addr;
        logic [31:0] word;
        int          delay;
        arready <= 1'b0;
        r       <= '0;
        forever begin
            @(posedge clk);
            if (ar.arvalid) begin
                delay = int'(rand_bits(3));
                repeat (delay) @(posedge clk);
                arready <= 1'b1;
                @(posedge clk);
                arready <= 1'b0;
                compare_val("arvalid", ar.arvalid, 1);
                addr = ar.araddr;
                ar_count++;
                if (araddr_q.size() == 0) begin
                    $display("an AR transfer appeared with no read expected");
                    errors++;
                end else begin
                    compare_val("araddr", addr, araddr_q.pop_front());
                end
                if (addr[31:28] != 4'hd) begin
                    for (int b = 0; b < 4; b++) begin
                        word[8*b +: 8] = mem_byte(addr + 32'(b));
                    end
                    delay = int'(rand_bits(3));
                    repeat (delay) @(posedge clk);
                    r.rdata  <= word;
                    r.rresp  <= (addr[31:28] == 4'he) ? 2'b10 : 2'b00;
                    r.rvalid <= 1'b1;
                    @(posedge clk);
                    while (!rready) @(posedge clk);
                    r.rvalid <= 1'b0;
                end
            end
        end
    end

    initial begin : ready_stalls
        out_ready <= 1'b0;
        forever begin
            @(posedge clk);
            if (stall_heavy) begin
                out_ready <= (rand_bits(2) == 32'd0);
            end else begin
                out_ready <= (rand_bits(2) != 32'd0);
            end
        end
    end

    initial begin : output_monitor
        mem_pkg::mem_res_t held;
        logic              was_stalled;
        logic              busy;
        was_stalled = 1'b0;
        busy        = 1'b0;
        held        = '0;
        forever begin
            @(posedge clk);
            if (rst_n) begin
                if (was_stalled) begin
                    compare_val("out_valid", out_valid, 1);
                    check_result("held ", out_res, held);
                end
                // a bundle is in flight from acceptance until its result is taken
                if (busy) begin
                    compare_val("in_ready", in_ready, 0);
                end
                if (out_valid && out_ready) begin
                    if (exp_q.size() == 0) begin
                        $display("a result came out with no request outstanding");
                        errors++;
                    end else begin
                        check_result("", out_res, exp_q.pop_front());
                    end
                    busy = 1'b0;
                end
                if (in_valid && in_ready) begin
                    busy = 1'b1;
                end
                was_stalled = out_valid && !out_ready;
                held        = out_res;
            end
        end
    end

    // worst case per request is a full read timeout plus slack
    initial begin : watchdog
        int limit;
        limit = 64;
        for (int t = 0; t < 6; t++) begin
            limit += test_len[t] * (mem_pkg::TIMEOUT_CYCLES + 32);
        end
        repeat (limit) @(posedge clk);
        $display("the run timed out after %0d cycles before all tests finished", limit);
        $display("Result: FAILED");
        $finish;
    end

endmodule

//--- verilog.f
mem_pkg.sv
mem_wait_timer.sv
mem_addr_gen.sv
tlb.sv
mem_axi_read.sv
opswap.sv
mem_ctrl_fsm.sv
mem_stage.sv
tb_clock_gen.sv
mem_stage_tb.sv

//--- run_sim.sh
#!/bin/sh
# build and run the memory stage testbench with Verilator

LOG=sim.log

verilator --binary --timing -Wno-fatal --top-module mem_stage_tb -f verilog.f -o mem_stage_sim
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

./obj_dir/mem_stage_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Result: FAILED" "$LOG"; then
    exit 1
fi
if grep -q "Result: PASSED" "$LOG"; then
    exit 0
fi
echo "no result line found in $LOG"
exit 1
